//--- tb.f
+incdir+include
verilog/decomp_pkg.sv
verilog/frame_ram.sv
verilog/mem_arbiter.sv
verilog/uart_word_loader.sv
verilog/yuv_rgb_converter.sv
verilog/decomp_top.sv
test/tb_clock_gen.sv
test/decomp_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP = decomp_tb
FILELIST = tb.f
OBJ_DIR = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/decomp_tb.sv
// Decompressor testbench
// Loads a YUV image over UART, then checks memory, RGB output, mode and framing
`default_nettype none

`include "decomp_macros.svh"

module decomp_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS_SENT = 48;
	localparam int DONE_TIMEOUT = 4000;
	localparam int READ_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 40;

	logic CLOCK_50_I;
	logic resetn;
	logic reset_req;
	logic uart_rx;
	logic rd_req;
	decomp_pkg::mem_addr_t rd_addr;
	decomp_pkg::mem_word_t rd_data;
	logic rd_valid;
	logic busy;
	logic done;
	logic frame_error;

	decomp_pkg::sample_t y_smp [2*`PAIR_COUNT];
	decomp_pkg::sample_t u_smp [`PAIR_COUNT];
	decomp_pkg::sample_t v_smp [`PAIR_COUNT];
	decomp_pkg::mem_word_t sent_words [WORDS_SENT];   // Word i lands at address i
	decomp_pkg::mem_word_t rgb_exp [3*`PAIR_COUNT];
	int error_count;
	int test_count;
	int failed_tests;

	tb_clock_gen i_clock_gen (
		.reset_req  (reset_req),
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn)
	);

	decomp_top i_dut (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.uart_rx     (uart_rx),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.busy        (busy),
		.done        (done),
		.frame_error (frame_error)
	);

	// Floor of acc / 65536, saturated to one byte
	function automatic decomp_pkg::sample_t scale_and_clip(input longint acc);
		longint q;
		q = acc / 65536;
		if (acc < 0 && acc % 65536 != 0) begin
			q = q - 1;   // Division truncates toward zero
		end
		if (q < 0) begin
			return 8'd0;
		end
		if (q > 255) begin
			return 8'd255;
		end
		return decomp_pkg::sample_t'(q);
	endfunction

	task automatic build_image();
		longint luma;
		longint r_c, g_c, b_c;
		decomp_pkg::sample_t r [2];
		decomp_pkg::sample_t g [2];
		decomp_pkg::sample_t b [2];
		for (int i = 0; i < 2*`PAIR_COUNT; i++) begin
			y_smp[i] = decomp_pkg::sample_t'($urandom);
		end
		for (int k = 0; k < `PAIR_COUNT; k++) begin
			u_smp[k] = decomp_pkg::sample_t'($urandom);
			v_smp[k] = decomp_pkg::sample_t'($urandom);
		end
		// Saturate high on pair 0, low on pair 1
		y_smp[0] = 8'd255;
		y_smp[1] = 8'd255;
		v_smp[0] = 8'd255;
		y_smp[2] = 8'd0;
		y_smp[3] = 8'd0;
		u_smp[1] = 8'd0;
		for (int k = 0; k < `PAIR_COUNT; k++) begin
			sent_words[`Y_BASE + k] = {y_smp[2*k], y_smp[2*k+1]};
			sent_words[`U_BASE + k] = {u_smp[k], decomp_pkg::byte_t'($urandom)};
			sent_words[`V_BASE + k] = {v_smp[k], decomp_pkg::byte_t'($urandom)};
			r_c = 104595 * (longint'(v_smp[k]) - 128);
			g_c = -25624 * (longint'(u_smp[k]) - 128) - 53281 * (longint'(v_smp[k]) - 128);
			b_c = 132251 * (longint'(u_smp[k]) - 128);
			for (int p = 0; p < 2; p++) begin
				luma = 76284 * (longint'(y_smp[2*k+p]) - 16);
				r[p] = scale_and_clip(luma + r_c);
				g[p] = scale_and_clip(luma + g_c);
				b[p] = scale_and_clip(luma + b_c);
			end
			rgb_exp[3*k] = {r[0], g[0]};
			rgb_exp[3*k+1] = {b[0], r[1]};
			rgb_exp[3*k+2] = {g[1], b[1]};
		end
	endtask

	task automatic compare_word(input string name, input decomp_pkg::mem_word_t got,
		input decomp_pkg::mem_word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (error_count == errs_before) begin
			$display("%-14s passed", name);
		end else begin
			failed_tests++;
			$display("%-14s FAILED with %0d errors", name, error_count - errs_before);
		end
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		do begin
			@(negedge CLOCK_50_I);
			waited++;
		end while (resetn !== 1'b1 && waited < RESET_TIMEOUT);
		if (resetn !== 1'b1) begin
			$display("Reset was never released");
			error_count++;
		end
	endtask

	task automatic apply_reset();
		int waited;
		waited = 0;
		@(negedge CLOCK_50_I);
		reset_req <= 1'b1;
		@(negedge CLOCK_50_I);
		reset_req <= 1'b0;
		while (resetn !== 1'b0 && waited < RESET_TIMEOUT) begin
			@(negedge CLOCK_50_I);
			waited++;
		end
		if (resetn !== 1'b0) begin
			$display("Reset request did not pull resetn low");
			error_count++;
		end
		wait_reset_release();
	endtask

	// One UART bit, entered on a falling edge
	task automatic hold_line(input logic level);
		uart_rx = level;
		repeat (`UART_CLKS_PER_BIT) @(negedge CLOCK_50_I);
	endtask

	task automatic send_byte(input decomp_pkg::byte_t data, input logic stop_ok);
		hold_line(1'b0);   // Start bit
		for (int i = 0; i < 8; i++) begin
			hold_line(data[i]);   // LSB first
		end
		hold_line(stop_ok);
		hold_line(1'b1);
		hold_line(1'b1);
	endtask

	task automatic read_word(input decomp_pkg::mem_addr_t addr,
		output decomp_pkg::mem_word_t data);
		int waited;
		logic got;
		waited = 0;
		got = 1'b0;
		data = 'x;
		@(negedge CLOCK_50_I);
		rd_addr = addr;
		rd_req = 1'b1;   // Held until rd_valid
		while (!got && waited < READ_TIMEOUT) begin
			@(negedge CLOCK_50_I);
			waited++;
			if (rd_valid) begin
				data = rd_data;
				got = 1'b1;
			end
		end
		rd_req = 1'b0;
		if (!got) begin
			$display("Timed out waiting for read data at address 0x%h", addr);
			error_count++;
		end
	endtask

	task automatic wait_done(output int cycles, output int busy_low);
		cycles = 0;
		busy_low = 0;
		while (!done && cycles < DONE_TIMEOUT) begin
			if (!busy) begin
				busy_low++;
			end
			@(negedge CLOCK_50_I);
			cycles++;
		end
		if (!done) begin
			$display("Timed out after %0d cycles waiting for done", cycles);
			error_count++;
		end
	endtask

	task automatic test_reset_state();
		int errs;
		errs = error_count;
		@(negedge CLOCK_50_I);
		compare_flag("busy", busy, 1'b0);
		compare_flag("done", done, 1'b0);
		compare_flag("frame_error", frame_error, 1'b0);
		compare_flag("rd_valid", rd_valid, 1'b0);
		repeat (100) @(negedge CLOCK_50_I);   // Idle line starts no load
		compare_flag("busy", busy, 1'b0);
		report_test("reset_state", errs);
	endtask

	task automatic test_mode_sequence();
		int errs;
		int cycles;
		int busy_low;
		errs = error_count;
		@(negedge CLOCK_50_I);
		compare_flag("busy", busy, 1'b0);
		for (int i = 0; i < WORDS_SENT; i++) begin
			send_byte(sent_words[i][15:8], 1'b1);
			compare_flag("busy", busy, 1'b1);
			send_byte(sent_words[i][7:0], 1'b1);
			compare_flag("busy", busy, 1'b1);
			compare_flag("done", done, 1'b0);
		end
		wait_done(cycles, busy_low);
		// Last write lands about one bit time before the final byte returns
		if (cycles < `LOAD_IDLE_CYCLES - `UART_CLKS_PER_BIT) begin
			$display("done rose only %0d cycles after the last byte", cycles);
			error_count++;
		end
		if (busy_low != 0) begin
			$display("busy dropped for %0d cycles before done rose", busy_low);
			error_count++;
		end
		repeat (50) begin
			@(negedge CLOCK_50_I);
			compare_flag("done", done, 1'b1);
			compare_flag("busy", busy, 1'b0);
		end
		report_test("mode_sequence", errs);
	endtask

	task automatic test_readback();
		int errs;
		decomp_pkg::mem_word_t data;
		errs = error_count;
		for (int a = `Y_BASE; a < `V_BASE + `PAIR_COUNT; a++) begin
			read_word(decomp_pkg::mem_addr_t'(a), data);
			compare_word($sformatf("rd_data[0x%h]", a), data, sent_words[a]);
		end
		report_test("load_readback", errs);
	endtask

	task automatic test_conversion();
		int errs;
		decomp_pkg::mem_word_t data;
		errs = error_count;
		for (int i = 0; i < 3*`PAIR_COUNT; i++) begin
			read_word(decomp_pkg::mem_addr_t'(`RGB_BASE + i), data);
			compare_word($sformatf("rd_data[0x%h]", `RGB_BASE + i), data, rgb_exp[i]);
		end
		report_test("conversion", errs);
	endtask

	task automatic test_framing();
		int errs;
		int cycles;
		int busy_low;
		decomp_pkg::mem_word_t data;
		errs = error_count;
		apply_reset();
		compare_flag("frame_error", frame_error, 1'b0);
		compare_flag("done", done, 1'b0);
		send_byte(8'hC3, 1'b0);   // Low stop bit
		compare_flag("frame_error", frame_error, 1'b1);
		send_byte(8'h5A, 1'b1);
		send_byte(8'hA5, 1'b1);
		wait_done(cycles, busy_low);
		read_word('0, data);
		compare_word("rd_data[0x000]", data, 16'h5AA5);
		read_word(decomp_pkg::mem_addr_t'(1), data);   // Left from the first load
		compare_word("rd_data[0x001]", data, sent_words[1]);
		compare_flag("frame_error", frame_error, 1'b1);
		report_test("framing", errs);
	endtask

	initial begin
		void'($urandom(20));
		uart_rx = 1'b1;
		rd_req = 1'b0;
		rd_addr = '0;
		reset_req = 1'b0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		build_image();
		wait_reset_release();
		test_reset_state();
		test_mode_sequence();
		test_readback();
		test_conversion();
		test_framing();
		$display("%0d tests run, %0d failed, %0d check errors", test_count, failed_tests,
			error_count);
		if (error_count == 0 && failed_tests == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Testbench clock and reset source
// 100 ns clock, reset held low for 8 cycles at start and on request
`default_nettype none

module tb_clock_gen (
	input  logic reset_req,
	output logic CLOCK_50_I,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 50;

	logic [3:0] hold_cnt;   // Reset cycles still to go after this one

	initial begin
		CLOCK_50_I = 1'b0;
		resetn = 1'b0;
		hold_cnt = 4'd7;
	end

	always #HALF_PERIOD CLOCK_50_I = ~CLOCK_50_I;

	// Reset changes on the falling edge like every other DUT input
	always @(negedge CLOCK_50_I) begin
		if (reset_req) begin
			resetn <= 1'b0;
			hold_cnt <= 4'd7;
		end else if (hold_cnt != 4'd0) begin
			hold_cnt <= hold_cnt - 4'd1;
		end else begin
			resetn <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/decomp_top.sv
// Image decompressor top
// Mode FSM and load timeout around the UART loader, converter and frame memory
`default_nettype none

`include "decomp_macros.svh"

module decomp_top (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  uart_rx,
	input  logic                  rd_req,
	input  decomp_pkg::mem_addr_t rd_addr,
	output decomp_pkg::mem_word_t rd_data,
	output logic                  rd_valid,
	output logic                  busy,
	output logic                  done,
	output logic                  frame_error
);

	localparam int unsigned IDLE_W = $clog2(`LOAD_IDLE_CYCLES + 1);

	decomp_pkg::top_state_t top_state;
	logic [IDLE_W-1:0] idle_cnt;
	logic word_seen;
	logic cvt_start, cvt_done;

	logic ld_req;
	decomp_pkg::mem_addr_t ld_addr;
	decomp_pkg::mem_word_t ld_wdata;
	logic cv_req, cv_we, cv_gnt;
	decomp_pkg::mem_addr_t cv_addr;
	decomp_pkg::mem_word_t cv_wdata;
	decomp_pkg::mem_addr_t ram_addr;
	logic ram_we;
	decomp_pkg::mem_word_t ram_wdata, ram_rdata;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			top_state <= decomp_pkg::TOP_IDLE;
			idle_cnt <= '0;
			word_seen <= 1'b0;
			cvt_start <= 1'b0;
		end else begin
			cvt_start <= 1'b0;
			case (top_state)
			decomp_pkg::TOP_IDLE: begin
				idle_cnt <= '0;
				if (!uart_rx) begin
					top_state <= decomp_pkg::TOP_LOAD;  // First start bit
				end
			end
			decomp_pkg::TOP_LOAD: begin
				// Timer restarts with every word written
				if (ld_req) begin
					idle_cnt <= '0;
					word_seen <= 1'b1;
				end else if (idle_cnt != IDLE_W'(`LOAD_IDLE_CYCLES)) begin
					idle_cnt <= idle_cnt + 1'b1;
				end
				if (idle_cnt == IDLE_W'(`LOAD_IDLE_CYCLES) && word_seen) begin
					cvt_start <= 1'b1;
					top_state <= decomp_pkg::TOP_CONVERT;
				end
			end
			decomp_pkg::TOP_CONVERT: if (cvt_done) top_state <= decomp_pkg::TOP_DONE;
			default: top_state <= decomp_pkg::TOP_DONE;   // Held until reset
			endcase
		end
	end

	assign busy = (top_state == decomp_pkg::TOP_LOAD) || (top_state == decomp_pkg::TOP_CONVERT);
	assign done = (top_state == decomp_pkg::TOP_DONE);
	assign rd_data = ram_rdata;

	uart_word_loader i_loader (
		.CLOCK_50_I  (CLOCK_50_I),
		.resetn      (resetn),
		.uart_rx     (uart_rx),
		.wr_req      (ld_req),
		.wr_addr     (ld_addr),
		.wr_data     (ld_wdata),
		.frame_error (frame_error)
	);

	yuv_rgb_converter i_converter (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.start      (cvt_start),
		.mem_req    (cv_req),
		.mem_addr   (cv_addr),
		.mem_we     (cv_we),
		.mem_wdata  (cv_wdata),
		.mem_gnt    (cv_gnt),
		.mem_rdata  (ram_rdata),
		.done       (cvt_done)
	);

	// Read port completion is seen through rd_valid
	mem_arbiter i_arbiter (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.ld_req     (ld_req),
		.ld_addr    (ld_addr),
		.ld_wdata   (ld_wdata),
		.cv_req     (cv_req),
		.cv_addr    (cv_addr),
		.cv_we      (cv_we),
		.cv_wdata   (cv_wdata),
		.cv_gnt     (cv_gnt),
		.rp_req     (rd_req),
		.rp_addr    (rd_addr),
		.rp_gnt     (),
		.rp_valid   (rd_valid),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.ram_wdata  (ram_wdata)
	);

	frame_ram i_ram (
		.CLOCK_50_I (CLOCK_50_I),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.ram_wdata  (ram_wdata),
		.ram_rdata  (ram_rdata)
	);

endmodule

`default_nettype wire

//--- verilog/yuv_rgb_converter.sv
// YUV 4:2:2 to RGB converter
// Reads Y, U, V per pixel pair and writes three packed RGB words back
`default_nettype none

`include "decomp_macros.svh"

module yuv_rgb_converter (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  start,
	output logic                  mem_req,
	output decomp_pkg::mem_addr_t mem_addr,
	output logic                  mem_we,
	output decomp_pkg::mem_word_t mem_wdata,
	input  logic                  mem_gnt,
	input  decomp_pkg::mem_word_t mem_rdata,
	output logic                  done
);

	decomp_pkg::cvt_state_t state;
	decomp_pkg::cvt_state_t rd_slot;   // Which read is in flight
	logic rd_pend;
	decomp_pkg::mem_addr_t pair_idx;
	decomp_pkg::mem_addr_t rgb_addr;
	logic last_pair;
	decomp_pkg::mem_word_t y_word;
	decomp_pkg::sample_t u_smp, v_smp;
	decomp_pkg::sample_t r0, g0, b0, r1, g1, b1;
	logic signed [31:0] y0_term, y1_term;
	logic signed [31:0] r_chroma, g_chroma, b_chroma;

	// Scale down by 65536 with floor, then saturate to a byte
	function automatic decomp_pkg::sample_t clip8(input logic signed [31:0] acc);
		logic signed [31:0] q;
		q = acc >>> 16;
		if (q < 0) begin
			return 8'd0;
		end else if (q > 255) begin
			return 8'd255;
		end
		return q[7:0];
	endfunction

	assign last_pair = (pair_idx == decomp_pkg::mem_addr_t'(`PAIR_COUNT - 1));

	always_comb begin
		mem_req = 1'b1;
		mem_we = 1'b0;
		mem_addr = rgb_addr;
		mem_wdata = {r0, g0};
		case (state)
		decomp_pkg::CVT_RD_Y: mem_addr = decomp_pkg::mem_addr_t'(`Y_BASE) + pair_idx;
		decomp_pkg::CVT_RD_U: mem_addr = decomp_pkg::mem_addr_t'(`U_BASE) + pair_idx;
		decomp_pkg::CVT_RD_V: mem_addr = decomp_pkg::mem_addr_t'(`V_BASE) + pair_idx;
		decomp_pkg::CVT_WR0: mem_we = 1'b1;
		decomp_pkg::CVT_WR1: begin
			mem_we = 1'b1;
			mem_wdata = {b0, r1};
		end
		decomp_pkg::CVT_WR2: begin
			mem_we = 1'b1;
			mem_wdata = {g1, b1};
		end
		default: mem_req = 1'b0;
		endcase
	end

	// Luma and shared chroma products
	always_comb begin
		y0_term = 32'sd76284 * ($signed({24'd0, y_word[15:8]}) - 32'sd16);
		y1_term = 32'sd76284 * ($signed({24'd0, y_word[7:0]}) - 32'sd16);
		r_chroma = 32'sd104595 * ($signed({24'd0, v_smp}) - 32'sd128);
		g_chroma = -(32'sd25624 * ($signed({24'd0, u_smp}) - 32'sd128))
			- 32'sd53281 * ($signed({24'd0, v_smp}) - 32'sd128);
		b_chroma = 32'sd132251 * ($signed({24'd0, u_smp}) - 32'sd128);
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= decomp_pkg::CVT_IDLE;
			rd_slot <= decomp_pkg::CVT_IDLE;
			rd_pend <= 1'b0;
			pair_idx <= '0;
			rgb_addr <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			rd_pend <= mem_req & mem_gnt & ~mem_we;
			rd_slot <= state;
			if (mem_req && mem_gnt && mem_we) begin
				rgb_addr <= rgb_addr + 1'b1;
			end
			case (state)
			decomp_pkg::CVT_IDLE: begin
				if (start) begin
					pair_idx <= '0;
					rgb_addr <= decomp_pkg::mem_addr_t'(`RGB_BASE);
					state <= decomp_pkg::CVT_RD_Y;
				end
			end
			decomp_pkg::CVT_RD_Y: if (mem_gnt) state <= decomp_pkg::CVT_RD_U;
			decomp_pkg::CVT_RD_U: if (mem_gnt) state <= decomp_pkg::CVT_RD_V;
			decomp_pkg::CVT_RD_V: if (mem_gnt) state <= decomp_pkg::CVT_WAIT_V;
			decomp_pkg::CVT_WAIT_V: state <= decomp_pkg::CVT_CALC;
			decomp_pkg::CVT_CALC: state <= decomp_pkg::CVT_WR0;
			decomp_pkg::CVT_WR0: if (mem_gnt) state <= decomp_pkg::CVT_WR1;
			decomp_pkg::CVT_WR1: if (mem_gnt) state <= decomp_pkg::CVT_WR2;
			decomp_pkg::CVT_WR2: begin
				if (mem_gnt) begin
					pair_idx <= pair_idx + 1'b1;
					if (last_pair) begin
						done <= 1'b1;
						state <= decomp_pkg::CVT_IDLE;
					end else begin
						state <= decomp_pkg::CVT_RD_Y;
					end
				end
			end
			default: state <= decomp_pkg::CVT_IDLE;
			endcase
		end
	end

	// Sample capture and result registers
	always_ff @(posedge CLOCK_50_I) begin
		if (rd_pend) begin
			case (rd_slot)
			decomp_pkg::CVT_RD_Y: y_word <= mem_rdata;
			decomp_pkg::CVT_RD_U: u_smp <= mem_rdata[15:8];
			default: v_smp <= mem_rdata[15:8];
			endcase
		end
		if (state == decomp_pkg::CVT_CALC) begin
			r0 <= clip8(y0_term + r_chroma);
			g0 <= clip8(y0_term + g_chroma);
			b0 <= clip8(y0_term + b_chroma);
			r1 <= clip8(y1_term + r_chroma);
			g1 <= clip8(y1_term + g_chroma);
			b1 <= clip8(y1_term + b_chroma);
		end
	end

	// Results only ever land in the RGB region
	a_wr_in_rgb: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(mem_req && mem_we) |-> (mem_addr >= decomp_pkg::mem_addr_t'(`RGB_BASE)
			&& mem_addr < decomp_pkg::mem_addr_t'(`RGB_BASE + 3*`PAIR_COUNT)));

endmodule

`default_nettype wire

//--- verilog/uart_word_loader.sv
// UART receive loader
// Pairs received bytes into words and writes them to consecutive addresses
`default_nettype none

`include "decomp_macros.svh"

module uart_word_loader (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  uart_rx,
	output logic                  wr_req,
	output decomp_pkg::mem_addr_t wr_addr,
	output decomp_pkg::mem_word_t wr_data,
	output logic                  frame_error
);

	localparam int unsigned CNT_W = $clog2(`UART_CLKS_PER_BIT);

	logic [2:0] rx_pipe;          // Two sync stages plus edge history
	logic rx_bit;
	logic rx_fall;
	decomp_pkg::uart_state_t state;
	logic [CNT_W-1:0] clk_cnt;
	logic bit_end;
	logic [2:0] bit_cnt;
	decomp_pkg::byte_t rx_shift;
	decomp_pkg::byte_t hi_byte;
	logic have_hi;
	logic [`ADDR_W:0] word_cnt;   // One spare bit to catch overrun

	assign rx_bit = rx_pipe[1];
	assign rx_fall = rx_pipe[2] & ~rx_pipe[1];
	assign bit_end = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
	assign wr_addr = word_cnt[`ADDR_W-1:0];

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			rx_pipe <= 3'b111;      // Line idles high
			state <= decomp_pkg::UART_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			have_hi <= 1'b0;
			word_cnt <= '0;
			wr_req <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			rx_pipe <= {rx_pipe[1:0], uart_rx};
			wr_req <= 1'b0;
			if (wr_req) begin
				word_cnt <= word_cnt + 1'b1;
			end
			case (state)
			decomp_pkg::UART_IDLE: begin
				clk_cnt <= '0;
				if (rx_fall) begin
					state <= decomp_pkg::UART_START;
				end
			end
			decomp_pkg::UART_START: begin
				// Middle of the start bit
				if (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT / 2 - 1)) begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					state <= rx_bit ? decomp_pkg::UART_IDLE : decomp_pkg::UART_DATA;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			decomp_pkg::UART_DATA: begin
				clk_cnt <= clk_cnt + 1'b1;   // Wraps at the bit end
				if (bit_end) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) begin
						state <= decomp_pkg::UART_STOP;
					end
				end
			end
			decomp_pkg::UART_STOP: begin
				clk_cnt <= clk_cnt + 1'b1;
				if (bit_end) begin
					state <= decomp_pkg::UART_IDLE;
					if (!rx_bit) begin
						frame_error <= 1'b1;  // Byte dropped
					end else if (have_hi) begin
						wr_req <= 1'b1;
						have_hi <= 1'b0;
					end else begin
						have_hi <= 1'b1;
					end
				end
			end
			default: state <= decomp_pkg::UART_IDLE;
			endcase
		end
	end

	// Byte assembly, LSB first on the line
	always_ff @(posedge CLOCK_50_I) begin
		if (state == decomp_pkg::UART_DATA && bit_end) begin
			rx_shift <= {rx_bit, rx_shift[7:1]};
		end
		if (state == decomp_pkg::UART_STOP && bit_end && rx_bit) begin
			if (have_hi) begin
				wr_data <= {hi_byte, rx_shift};
			end else begin
				hi_byte <= rx_shift;    // First byte is the upper half
			end
		end
	end

	a_addr_in_range: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		wr_req |-> (word_cnt < `MEM_WORDS));

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
// Frame memory arbiter
// Fixed priority loader, then converter, then read port; one grant per cycle
`default_nettype none

module mem_arbiter (
	input  logic                  CLOCK_50_I,
	input  logic                  resetn,
	input  logic                  ld_req,
	input  decomp_pkg::mem_addr_t ld_addr,
	input  decomp_pkg::mem_word_t ld_wdata,
	input  logic                  cv_req,
	input  decomp_pkg::mem_addr_t cv_addr,
	input  logic                  cv_we,
	input  decomp_pkg::mem_word_t cv_wdata,
	output logic                  cv_gnt,
	input  logic                  rp_req,
	input  decomp_pkg::mem_addr_t rp_addr,
	output logic                  rp_gnt,
	output logic                  rp_valid,
	output decomp_pkg::mem_addr_t ram_addr,
	output logic                  ram_we,
	output decomp_pkg::mem_word_t ram_wdata
);

	// Loader strobe always wins, so it needs no grant back
	assign cv_gnt = cv_req & ~ld_req;
	assign rp_gnt = rp_req & ~ld_req & ~cv_req;

	always_comb begin
		ram_addr = rp_addr;      // Read port is the fallback
		ram_we = 1'b0;
		ram_wdata = cv_wdata;
		if (ld_req) begin
			ram_addr = ld_addr;
			ram_we = 1'b1;
			ram_wdata = ld_wdata;
		end else if (cv_req) begin
			ram_addr = cv_addr;
			ram_we = cv_we;
		end
	end

	// RAM data for the read port lands one cycle after its grant
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			rp_valid <= 1'b0;
		end else begin
			rp_valid <= rp_gnt;
		end
	end

	// A waiting requester keeps asking until it is served
	a_cv_held: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(cv_req && !cv_gnt) |=> cv_req);
	a_rp_held: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(rp_req && !rp_gnt) |=> rp_req);

endmodule

`default_nettype wire

//--- verilog/frame_ram.sv
// Frame memory
// Single port synchronous RAM, read data one cycle after the address
`default_nettype none

`include "decomp_macros.svh"

module frame_ram (
	input  logic                  CLOCK_50_I,
	input  decomp_pkg::mem_addr_t ram_addr,
	input  logic                  ram_we,
	input  decomp_pkg::mem_word_t ram_wdata,
	output decomp_pkg::mem_word_t ram_rdata
);

	decomp_pkg::mem_word_t mem [`MEM_WORDS];

	always_ff @(posedge CLOCK_50_I) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
		// Read before write on the same address
		ram_rdata <= mem[ram_addr];
	end

endmodule

`default_nettype wire

//--- verilog/decomp_pkg.sv
// Decompressor shared types
// Word, address and sample vectors plus the FSM state encodings
`default_nettype none

`include "decomp_macros.svh"

package decomp_pkg;

	typedef logic [15:0] mem_word_t;
	typedef logic [`ADDR_W-1:0] mem_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [7:0] sample_t;    // One Y, U, V, R, G or B value

	typedef enum logic [1:0] {
		TOP_IDLE,
		TOP_LOAD,
		TOP_CONVERT,
		TOP_DONE
	} top_state_t;

	// Converter steps for one pixel pair
	typedef enum logic [3:0] {
		CVT_IDLE,
		CVT_RD_Y,
		CVT_RD_U,
		CVT_RD_V,
		CVT_WAIT_V,   // Last read word arriving
		CVT_CALC,
		CVT_WR0,
		CVT_WR1,
		CVT_WR2
	} cvt_state_t;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

endpackage

`default_nettype wire

//--- include/decomp_macros.svh
// Decompressor sizes and timing constants
// Frame memory layout, pixel count, UART bit time and load timeout
`ifndef DECOMP_MACROS_SVH
`define DECOMP_MACROS_SVH

// Frame memory geometry
`define MEM_WORDS 1024
`define ADDR_W 10

// Region bases inside the frame memory
`define Y_BASE 0
`define U_BASE 16
`define V_BASE 32
`define RGB_BASE 64     // Three packed words per pair

// Number of pixel pairs in the image
`define PAIR_COUNT 16

// Clock cycles per UART bit
`define UART_CLKS_PER_BIT 8

// Quiet cycles after the last word before the load ends
`define LOAD_IDLE_CYCLES 400

`endif
